/* hdl/l2_cache_pkg.sv */
// l2 cache widths, address fields, request and fill structs, way one-hot type
package l2_cache_pkg;

    localparam int tag_w     = 17;
    localparam int index_w   = 9;
    localparam int offset_w  = 2;
    localparam int ways      = 4;
    localparam int word_w    = 128;
    localparam int line_w    = 512;
    localparam int words     = line_w / word_w;   // words per line
    localparam int sets      = 1 << index_w;
    localparam int way_sel_w = $clog2(ways);      // binary way number

    // byte address as seen by the l2 slice
    typedef struct packed {
        logic [tag_w-1:0]    tag;
        logic [index_w-1:0]  index;
        logic [offset_w-1:0] offset;
        logic [3:0]          byte_off;            // byte within word, ignored
    } l2_addr_t;

    // read or write from l1, one-cycle strobe
    typedef struct packed {
        logic              valid;
        logic              write;                 // 1 = write from l1
        l2_addr_t          addr;
        logic [word_w-1:0] wdata;
    } l2_req_t;

    // line refill from memory, only tag and index of addr are used
    typedef struct packed {
        logic              valid;
        l2_addr_t          addr;
        logic [line_w-1:0] line;
    } l2_fill_t;

    typedef logic [ways-1:0] way_onehot_t;        // one bit per way

endpackage

/* hdl/ram512x128.sv */
// single-port 512 x 128 synchronous ram with registered read enable
module ram512x128 (
    input  logic                               clk,
    input  logic [l2_cache_pkg::index_w-1:0]   address,
    input  logic                               wren,
    input  logic                               rden,
    input  logic [l2_cache_pkg::word_w-1:0]    data,
    output logic [l2_cache_pkg::word_w-1:0]    q
);
    import l2_cache_pkg::*;

    logic [word_w-1:0] mem [sets];

    always_ff @(posedge clk) begin
        if (wren) begin
            mem[address] <= data;
        end
    end

    // q keeps its last value while rden is low
    always_ff @(posedge clk) begin
        if (rden) begin
            q <= mem[address];    // old data on a same-address write
        end
    end

endmodule

/* hdl/l2_tag_ram.sv */
// l2 tag store: tags, valid bits, round-robin pointers, hit compare, way enables
module l2_tag_ram (
    input  logic                      clk,
    input  logic                      rst_n,
    input  l2_cache_pkg::l2_req_t     req,
    input  l2_cache_pkg::l2_fill_t    fill,
    output logic                      tagcomp_hit,
    output l2_cache_pkg::way_onehot_t hit_way,
    output logic                      miss,
    output l2_cache_pkg::way_onehot_t we_l2,
    output l2_cache_pkg::way_onehot_t we_mem,
    output l2_cache_pkg::way_onehot_t re
);
    import l2_cache_pkg::*;

    logic [ways-1:0][tag_w-1:0] tag_q   [sets];
    way_onehot_t                valid_q [sets];
    logic [way_sel_w-1:0]       rr_q    [sets];   // next victim when set is full

    logic [ways-1:0][tag_w-1:0] set_tag;
    way_onehot_t                set_valid;
    way_onehot_t                match;
    logic                       req_act;
    way_onehot_t                fill_valid;
    logic                       set_full;
    logic [way_sel_w-1:0]       victim;

    assign req_act   = req.valid && !fill.valid;  // fill has priority
    assign set_tag   = tag_q[req.addr.index];
    assign set_valid = valid_q[req.addr.index];

    always_comb begin
        for (int w = 0; w < ways; w++) begin
            match[w] = set_valid[w] && (set_tag[w] == req.addr.tag);
        end
    end

    assign hit_way     = req_act ? match : '0;
    assign tagcomp_hit = |hit_way;
    assign miss        = req_act && !(|match);
    assign we_l2       = req.write ? hit_way : '0;
    assign re          = req.write ? '0 : hit_way;

    // victim: lowest invalid way, else the round-robin pointer
    assign fill_valid = valid_q[fill.addr.index];
    assign set_full   = &fill_valid;

    always_comb begin
        victim = rr_q[fill.addr.index];
        for (int w = ways - 1; w >= 0; w--) begin
            if (!fill_valid[w]) begin
                victim = way_sel_w'(w);
            end
        end
    end

    always_comb begin
        for (int w = 0; w < ways; w++) begin
            we_mem[w] = fill.valid && (victim == way_sel_w'(w));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < sets; s++) begin
                valid_q[s] <= '0;
                rr_q[s]    <= '0;
            end
        end else if (fill.valid) begin
            valid_q[fill.addr.index][victim] <= 1'b1;
            if (set_full) begin
                rr_q[fill.addr.index] <= rr_q[fill.addr.index] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill.valid) begin
            tag_q[fill.addr.index][victim] <= fill.addr.tag;
        end
    end

endmodule

/* hdl/l2_data_ram.sv */
// l2 data store: write source mux, per-word write enables, sixteen ram banks
module l2_data_ram (
    input  logic                                                clk,
    input  logic [l2_cache_pkg::index_w-1:0]                    l2_index_mem,
    input  logic [l2_cache_pkg::index_w-1:0]                    l2_index_l2,
    input  logic [l2_cache_pkg::line_w-1:0]                     mem_rd,
    input  logic [l2_cache_pkg::offset_w-1:0]                   offset,
    input  logic [l2_cache_pkg::word_w-1:0]                     rd_to_l2,
    input  logic                                                wd_from_mem_en,
    input  logic                                                wd_from_l1_en,
    input  logic                                                tagcomp_hit,
    input  l2_cache_pkg::way_onehot_t                           we_mem,
    input  l2_cache_pkg::way_onehot_t                           we_l2,
    input  l2_cache_pkg::way_onehot_t                           re,
    output logic [l2_cache_pkg::ways-1:0][l2_cache_pkg::line_w-1:0] way_rd
);
    import l2_cache_pkg::*;

    logic [words-1:0][word_w-1:0] wdata;
    logic [index_w-1:0]           index;
    way_onehot_t                  way_we;
    logic                         word_mode;
    logic [ways-1:0][words-1:0]   wr_en;

    // memory fill wins over an l1 write in the same cycle
    always_comb begin
        if (wd_from_mem_en) begin
            wdata  = mem_rd;
            way_we = we_mem;
            index  = l2_index_mem;
        end else if (wd_from_l1_en) begin
            wdata  = {words{rd_to_l2}};   // only the offset bank is enabled
            way_we = we_l2;
            index  = l2_index_l2;
        end else begin
            wdata  = {words{rd_to_l2}};
            way_we = '0;
            index  = l2_index_l2;         // read address
        end
    end

    assign word_mode = tagcomp_hit && !wd_from_mem_en;

    // single word under a hit, whole line on a fill
    always_comb begin
        for (int w = 0; w < ways; w++) begin
            for (int b = 0; b < words; b++) begin
                if (word_mode) begin
                    wr_en[w][b] = way_we[w] && (offset == offset_w'(b));
                end else begin
                    wr_en[w][b] = way_we[w];
                end
            end
        end
    end

    // four word banks per way share address and read enable
    for (genvar w = 0; w < ways; w++) begin : g_way
        for (genvar b = 0; b < words; b++) begin : g_word
            ram512x128 u_bank (
                .clk     (clk),
                .address (index),
                .wren    (wr_en[w][b]),
                .rden    (re[w]),
                .data    (wdata[b]),
                .q       (way_rd[w][b*word_w +: word_w])
            );
        end
    end

endmodule

/* hdl/l2_word_select.sv */
// l2 read word selector: registers hit way and offset, muxes the read word
module l2_word_select (
    input  logic                                                     clk,
    input  logic                                                     rst_n,
    input  logic [l2_cache_pkg::ways-1:0][l2_cache_pkg::line_w-1:0]  way_rd,
    input  l2_cache_pkg::way_onehot_t                                hit_way,
    input  logic [l2_cache_pkg::offset_w-1:0]                        offset,
    input  logic                                                     rd_hit,
    output logic [l2_cache_pkg::word_w-1:0]                          rd_data,
    output logic                                                     rd_valid
);
    import l2_cache_pkg::*;

    way_onehot_t                  hit_way_q;
    logic [offset_w-1:0]          offset_q;
    logic [words-1:0][word_w-1:0] line_sel;

    // lines up with the one-cycle ram read
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_hit) begin
            hit_way_q <= hit_way;
            offset_q  <= offset;
        end
    end

    always_comb begin
        line_sel = '0;
        for (int w = 0; w < ways; w++) begin
            if (hit_way_q[w]) begin
                line_sel = way_rd[w];   // one-hot, at most one way
            end
        end
        rd_data = line_sel[offset_q];
    end

endmodule

/* hdl/l2_cache_top.sv */
// l2 cache slice top: tag store, data ram and read word selector
module l2_cache_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  l2_cache_pkg::l2_req_t           req,
    input  l2_cache_pkg::l2_fill_t          fill,
    output logic                            hit,
    output logic                            miss,
    output logic [l2_cache_pkg::word_w-1:0] rd_data,
    output logic                            rd_valid
);
    import l2_cache_pkg::*;

    logic                        tagcomp_hit;
    way_onehot_t                 hit_way;
    way_onehot_t                 we_l2;
    way_onehot_t                 we_mem;
    way_onehot_t                 re;
    logic                        wd_from_l1_en;
    logic                        rd_hit;
    logic [ways-1:0][line_w-1:0] way_rd;

    assign hit           = tagcomp_hit;
    assign wd_from_l1_en = |we_l2;    // write hit
    assign rd_hit        = |re;       // read hit

    l2_tag_ram u_tag_ram (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .fill        (fill),
        .tagcomp_hit (tagcomp_hit),
        .hit_way     (hit_way),
        .miss        (miss),
        .we_l2       (we_l2),
        .we_mem      (we_mem),
        .re          (re)
    );

    l2_data_ram u_data_ram (
        .clk            (clk),
        .l2_index_mem   (fill.addr.index),
        .l2_index_l2    (req.addr.index),
        .mem_rd         (fill.line),
        .offset         (req.addr.offset),
        .rd_to_l2       (req.wdata),
        .wd_from_mem_en (fill.valid),
        .wd_from_l1_en  (wd_from_l1_en),
        .tagcomp_hit    (tagcomp_hit),
        .we_mem         (we_mem),
        .we_l2          (we_l2),
        .re             (re),
        .way_rd         (way_rd)
    );

    l2_word_select u_word_select (
        .clk      (clk),
        .rst_n    (rst_n),
        .way_rd   (way_rd),
        .hit_way  (hit_way),
        .offset   (req.addr.offset),
        .rd_hit   (rd_hit),
        .rd_data  (rd_data),
        .rd_valid (rd_valid)
    );

endmodule

/* testbench/l2_cache_tb.sv */
// clock, reset, reference model, value check and directed tests for the l2 cache slice
module l2_cache_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import l2_cache_pkg::*;

    logic              clk;
    logic              rst_n;
    l2_req_t           req;
    l2_fill_t          fill;
    logic              hit;
    logic              miss;
    logic [word_w-1:0] rd_data;
    logic              rd_valid;
    integer            seed;

    // reference model with one entry per set and way
    logic [tag_w-1:0]  m_tag   [sets][ways];
    logic              m_valid [sets][ways];
    logic [1:0]        m_rr    [sets];
    logic [line_w-1:0] m_line  [sets][ways];

    l2_cache_top DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .fill     (fill),
        .hit      (hit),
        .miss     (miss),
        .rd_data  (rd_data),
        .rd_valid (rd_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [line_w-1:0] expected,
                               input logic [line_w-1:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    function automatic l2_addr_t make_addr(int tag, int index, int offset);
        l2_addr_t a;
        a.tag      = tag_w'(tag);
        a.index    = index_w'(index);
        a.offset   = offset_w'(offset);
        a.byte_off = 4'(tag + index);   // ignored by the slice
        return a;
    endfunction

    // way holding the tag or -1 on a miss
    function automatic int model_way(l2_addr_t a);
        int way;
        way = -1;
        for (int w = 0; w < ways; w++) begin
            if (m_valid[a.index][w] && m_tag[a.index][w] == a.tag) begin
                way = w;
            end
        end
        return way;
    endfunction

    task automatic model_fill(input l2_addr_t a, input logic [line_w-1:0] line,
                              output int way);
        way = -1;
        for (int w = 0; w < ways; w++) begin
            if (way < 0 && !m_valid[a.index][w]) begin
                way = w;                // lowest invalid way
            end
        end
        if (way < 0) begin
            way = m_rr[a.index];
            m_rr[a.index] = m_rr[a.index] + 2'd1;
        end
        m_valid[a.index][way] = 1'b1;
        m_tag[a.index][way]   = a.tag;
        m_line[a.index][way]  = line;
    endtask

    task automatic rand_line(output logic [line_w-1:0] line);
        for (int i = 0; i < line_w / 32; i++) begin
            line[i*32 +: 32] = $random(seed);
        end
    endtask

    task automatic rand_word(output logic [word_w-1:0] word);
        for (int i = 0; i < word_w / 32; i++) begin
            word[i*32 +: 32] = $random(seed);
        end
    endtask

    // cycles counts edges since the request edge
    task automatic wait_rd_valid(input string name, output int cycles);
        cycles = 1;
        while (rd_valid !== 1'b1) begin
            if (cycles >= 10) begin
                $display("timeout in %s: rd_valid did not go high within 10 cycles", name);
                $display("TEST RESULT: FAIL");
                $fatal(1, "rd_valid timeout");
            end
            @(posedge clk);
            #5;
            cycles++;
        end
    endtask

    task automatic do_read(input string name, input l2_addr_t a);
        int way;
        int cycles;
        way = model_way(a);
        @(posedge clk);
        #5;
        req.valid = 1'b1;
        req.write = 1'b0;
        req.addr  = a;
        req.wdata = '0;
        #40;                        // hit and miss settled mid cycle
        check_value({name, " hit"}, way >= 0, hit);
        check_value({name, " miss"}, way < 0, miss);
        @(posedge clk);
        #5;
        req.valid = 1'b0;
        if (way >= 0) begin
            wait_rd_valid(name, cycles);
            check_value({name, " latency"}, 1, cycles);
            check_value({name, " rd_data"},
                        m_line[a.index][way][a.offset*word_w +: word_w], rd_data);
            @(posedge clk);
            #5;
            check_value({name, " rd_valid pulse"}, 0, rd_valid);
        end else begin
            check_value({name, " rd_valid"}, 0, rd_valid);
        end
    endtask

    task automatic do_write(input string name, input l2_addr_t a,
                            input logic [word_w-1:0] data);
        int way;
        way = model_way(a);
        @(posedge clk);
        #5;
        req.valid = 1'b1;
        req.write = 1'b1;
        req.addr  = a;
        req.wdata = data;
        #40;
        check_value({name, " hit"}, way >= 0, hit);
        check_value({name, " miss"}, way < 0, miss);
        @(posedge clk);
        #5;
        req.valid = 1'b0;
        req.write = 1'b0;
        if (way >= 0) begin
            m_line[a.index][way][a.offset*word_w +: word_w] = data;
        end
        check_value({name, " rd_valid"}, 0, rd_valid);   // writes return nothing
    endtask

    task automatic do_fill(input string name, input l2_addr_t a,
                           input logic [line_w-1:0] line, output int way);
        @(posedge clk);
        #5;
        fill.valid = 1'b1;
        fill.addr  = a;
        fill.line  = line;
        model_fill(a, line, way);
        #40;
        check_value({name, " we_mem"}, 1 << way, DUT.u_tag_ram.we_mem);
        check_value({name, " hit"}, 0, hit);
        check_value({name, " miss"}, 0, miss);
        @(posedge clk);
        #5;
        fill.valid = 1'b0;
    endtask

    task automatic test_reset_miss();
        check_value("reset_miss idle hit", 0, hit);
        check_value("reset_miss idle miss", 0, miss);
        check_value("reset_miss idle rd_valid", 0, rd_valid);
        do_read("reset_miss a", make_addr(0, 0, 0));
        do_read("reset_miss b", make_addr(17'h1abcd, 9'h1ff, 3));
        do_read("reset_miss c", make_addr(5, 9'h0a5, 1));
    endtask

    task automatic test_fill_read();
        logic [line_w-1:0] line;
        int way;
        rand_line(line);
        do_fill("fill_read fill", make_addr(17'h01234, 9'h012, 0), line, way);
        check_value("fill_read way", 0, way);
        for (int off = 0; off < words; off++) begin
            do_read($sformatf("fill_read offset %0d", off), make_addr(17'h01234, 9'h012, off));
        end
    endtask

    task automatic test_write_hit();
        logic [word_w-1:0] data;
        rand_word(data);
        do_write("write_hit write", make_addr(17'h01234, 9'h012, 2), data);
        for (int off = 0; off < words; off++) begin
            do_read($sformatf("write_hit offset %0d", off), make_addr(17'h01234, 9'h012, off));
        end
    endtask

    task automatic test_write_miss();
        logic [word_w-1:0] data;
        logic [line_w-1:0] line;
        int way;
        rand_word(data);
        do_write("write_miss write", make_addr(17'h00777, 9'h033, 1), data);
        rand_line(line);
        do_fill("write_miss fill", make_addr(17'h00777, 9'h033, 0), line, way);
        for (int off = 0; off < words; off++) begin
            do_read($sformatf("write_miss offset %0d", off), make_addr(17'h00777, 9'h033, off));
        end
    endtask

    task automatic test_replacement();
        logic [line_w-1:0] line;
        int way;
        for (int t = 0; t < 6; t++) begin
            rand_line(line);
            do_fill($sformatf("replacement fill %0d", t), make_addr(17'h100 + t, 9'h140, 0),
                    line, way);
            check_value($sformatf("replacement way %0d", t), t % ways, way);   // 0 1 2 3 0 1
            for (int r = 0; r <= t; r++) begin
                do_read($sformatf("replacement tag %0d after fill %0d", r, t),
                        make_addr(17'h100 + r, 9'h140, r % words));
            end
        end
    endtask

    task automatic test_random();
        int                set_list [3];
        logic [line_w-1:0] line;
        logic [word_w-1:0] data;
        l2_addr_t          a;
        int                op;
        int                way;
        set_list = '{9'h007, 9'h100, 9'h1f3};
        for (int i = 0; i < 200; i++) begin
            op = $unsigned($random(seed)) % 4;
            a  = make_addr(17'h0aa0 + $unsigned($random(seed)) % 6,
                           set_list[$unsigned($random(seed)) % 3],
                           $unsigned($random(seed)) % words);
            if (op == 0 && model_way(a) < 0) begin
                rand_line(line);
                do_fill($sformatf("random %0d fill", i), a, line, way);
            end else if (op == 1) begin
                rand_word(data);
                do_write($sformatf("random %0d write", i), a, data);
            end else begin
                do_read($sformatf("random %0d read", i), a);
            end
        end
    endtask

    initial begin
        seed  = 6;
        rst_n = 1'b0;
        req   = '0;
        fill  = '0;
        for (int s = 0; s < sets; s++) begin
            m_rr[s] = 2'd0;
            for (int w = 0; w < ways; w++) begin
                m_valid[s][w] = 1'b0;
                m_tag[s][w]   = '0;
                m_line[s][w]  = '0;
            end
        end
        repeat (4) @(posedge clk);
        #5;
        rst_n = 1'b1;
        test_reset_miss();
        test_fill_read();
        test_write_hit();
        test_write_miss();
        test_replacement();
        test_random();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* all.f */
hdl/l2_cache_pkg.sv
hdl/ram512x128.sv
hdl/l2_tag_ram.sv
hdl/l2_data_ram.sv
hdl/l2_word_select.sv
hdl/l2_cache_top.sv
testbench/l2_cache_tb.sv
